/* hash_sched_pkg.sv */
package hash_sched_pkg;

    localparam int NUM_HASH_PE          = 4;
    localparam int ROW_SIZE             = 2;
    localparam int HASH_ISSUE_WIDTH     = NUM_HASH_PE;
    localparam int ISSUE_LOG2           = 2;
    localparam int ADDR_WIDTH           = 16;
    localparam int META_MATCH_LEN_WIDTH = 4;

    localparam int QUEUE_DEPTH          = 4;
    localparam int QUEUE_PTR_WIDTH      = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_WIDTH      = ISSUE_LOG2 + 1;

    // One history candidate from a hash row
    typedef struct packed {
        logic                            valid;
        logic [ADDR_WIDTH-1:0]           addr;
        logic [META_MATCH_LEN_WIDTH-1:0] meta_len;
        logic                            can_ext;
    } hist_entry_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]      addr;
        logic                       delim;
        logic [7:0]                 data;
        hist_entry_t [ROW_SIZE-1:0] row;
    } pe_lane_t;

    typedef struct packed {
        logic [NUM_HASH_PE-1:0]  mask;
        pe_lane_t [NUM_HASH_PE-1:0] lane;
    } pe_beat_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic                  delim;
        logic [7:0]            data;
        hist_entry_t           hist;  // Best candidate of the row
    } merged_lane_t;

    typedef struct packed {
        logic [NUM_HASH_PE-1:0]         mask;
        merged_lane_t [NUM_HASH_PE-1:0] lane;
    } merged_beat_t;

    typedef struct packed {
        hist_entry_t hist;
        logic [7:0]  data;
    } issue_slot_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]             head_addr;
        logic [HASH_ISSUE_WIDTH-1:0]       row_valid;
        issue_slot_t [HASH_ISSUE_WIDTH-1:0] slot;
        logic                              delim;
    } issue_row_t;

endpackage

/* hash_row_merge.sv */
`timescale 1ns/1ns

module hash_row_merge
    import hash_sched_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         in_valid,
    input  pe_beat_t     in_beat,
    output logic         in_ready,

    output logic         out_valid,
    output merged_beat_t out_beat,
    input  logic         out_ready
);

    merged_beat_t merged_d;
    logic         in_fire;

    // Longest valid meta length wins, strict compare keeps the lower index on a tie
    function automatic hist_entry_t pick_best(input hist_entry_t [ROW_SIZE-1:0] row);
        hist_entry_t best;
        best = '0;
        for (int k = 0; k < ROW_SIZE; k++) begin
            if (row[k].valid) begin
                if (!best.valid || (row[k].meta_len > best.meta_len)) begin
                    best = row[k];
                end
            end
        end
        return best;
    endfunction

    always_comb begin
        merged_d.mask = in_beat.mask;
        for (int i = 0; i < NUM_HASH_PE; i++) begin
            merged_d.lane[i].addr  = in_beat.lane[i].addr;
            merged_d.lane[i].delim = in_beat.lane[i].delim;
            merged_d.lane[i].data  = in_beat.lane[i].data;
            merged_d.lane[i].hist  = pick_best(in_beat.lane[i].row);
        end
    end

    // Register is free when empty or drained this cycle
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_beat <= merged_d;  // Payload only
        end
    end

endmodule

/* reorder_crossbar.sv */
`timescale 1ns/1ns

module reorder_crossbar
    import hash_sched_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         in_valid,
    input  merged_beat_t in_beat,
    output logic         in_ready,

    output logic         out_valid,
    output issue_row_t   out_row,
    input  logic         out_ready
);

    issue_row_t row_d;
    logic       in_fire;

    // Active lanes land in the slot named by their low address bits
    always_comb begin
        logic [ISSUE_LOG2-1:0] slot_idx;
        row_d    = '0;
        slot_idx = '0;
        for (int i = 0; i < NUM_HASH_PE; i++) begin
            if (in_beat.mask[i]) begin
                slot_idx                  = in_beat.lane[i].addr[ISSUE_LOG2-1:0];
                row_d.row_valid[slot_idx] = 1'b1;
                row_d.slot[slot_idx].hist = in_beat.lane[i].hist;
                row_d.slot[slot_idx].data = in_beat.lane[i].data;
                row_d.delim               = row_d.delim | in_beat.lane[i].delim;
                // All active lanes share the upper bits
                row_d.head_addr = {in_beat.lane[i].addr[ADDR_WIDTH-1:ISSUE_LOG2],
                                   {ISSUE_LOG2{1'b0}}};
            end
        end
    end

    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_row <= row_d;
        end
    end

endmodule

/* hash_row_synchronizer.sv */
`timescale 1ns/1ns

module hash_row_synchronizer
    import hash_sched_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic [QUEUE_CNT_WIDTH-1:0] cfg_max_queued_req_num,

    input  logic                       in_valid,
    input  issue_row_t                 in_row,
    output logic                       in_ready,

    output logic                       out_valid,
    output issue_row_t                 out_row,
    input  logic                       out_ready
);

    issue_row_t                 mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
    logic [QUEUE_CNT_WIDTH-1:0] count;
    logic                       wr_en;
    logic                       rd_en;
    issue_row_t                 head_row;

    // Limit meters requests waiting on the match units
    assign in_ready  = count < cfg_max_queued_req_num;
    assign out_valid = count != '0;
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_row;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                if (wr_ptr == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd_en) begin
                if (rd_ptr == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_row = mem[rd_ptr];

    // Empty slots never present a valid candidate
    always_comb begin
        out_row = head_row;
        for (int s = 0; s < HASH_ISSUE_WIDTH; s++) begin
            out_row.slot[s].hist.valid = head_row.slot[s].hist.valid & head_row.row_valid[s];
        end
    end

endmodule

/* post_hash_pe_scheduler.sv */
`timescale 1ns/1ns

module post_hash_pe_scheduler
    import hash_sched_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic [QUEUE_CNT_WIDTH-1:0] cfg_max_queued_req_num,

    input  logic                       input_valid,
    input  pe_beat_t                   input_beat,
    output logic                       input_ready,

    output logic                       output_valid,
    output issue_row_t                 output_row,
    input  logic                       output_ready
);

    logic         merge_valid;
    merged_beat_t merge_beat;
    logic         merge_ready;

    logic         rc_valid;
    issue_row_t   rc_row;
    logic         rc_ready;

    hash_row_merge merge_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (input_valid),
        .in_beat   (input_beat),
        .in_ready  (input_ready),
        .out_valid (merge_valid),
        .out_beat  (merge_beat),
        .out_ready (merge_ready)
    );

    reorder_crossbar rc_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (merge_valid),
        .in_beat   (merge_beat),
        .in_ready  (merge_ready),
        .out_valid (rc_valid),
        .out_row   (rc_row),
        .out_ready (rc_ready)
    );

    hash_row_synchronizer sync_inst (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .cfg_max_queued_req_num (cfg_max_queued_req_num),
        .in_valid               (rc_valid),
        .in_row                 (rc_row),
        .in_ready               (rc_ready),
        .out_valid              (output_valid),
        .out_row                (output_row),
        .out_ready              (output_ready)
    );

endmodule

/* tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int CHECK_W = 160;  // Wide enough for a whole issue_row_t

// Scan from the top index down so an equal length further down takes over
function automatic hist_entry_t best_candidate(input hist_entry_t [ROW_SIZE-1:0] cands);
    hist_entry_t winner;
    int          win_idx;
    winner  = '0;
    win_idx = -1;
    for (int k = ROW_SIZE - 1; k >= 0; k--) begin
        if (cands[k].valid && (win_idx < 0 || cands[k].meta_len >= cands[win_idx].meta_len)) begin
            win_idx = k;
        end
    end
    if (win_idx >= 0) begin
        winner = cands[win_idx];
    end
    return winner;
endfunction

// Expected issue row for one accepted input beat
function automatic issue_row_t expected_row(input pe_beat_t beat);
    issue_row_t exp_row;
    int         slot_idx;
    exp_row = '0;  // Unused slots stay all zero
    for (int i = 0; i < NUM_HASH_PE; i++) begin
        if (beat.mask[i]) begin
            slot_idx = int'(beat.lane[i].addr[ISSUE_LOG2-1:0]);
            exp_row.row_valid[slot_idx] = 1'b1;
            exp_row.slot[slot_idx].hist = best_candidate(beat.lane[i].row);
            exp_row.slot[slot_idx].data = beat.lane[i].data;
            exp_row.delim = exp_row.delim | beat.lane[i].delim;
            exp_row.head_addr = beat.lane[i].addr & ~ADDR_WIDTH'((1 << ISSUE_LOG2) - 1);
        end
    end
    return exp_row;
endfunction

task automatic check_value(input string name, input logic [CHECK_W-1:0] expected,
                           input logic [CHECK_W-1:0] actual);
    if (actual !== expected) begin
        error_count++;
        $display("FAIL %s expected %h actual %h", name, expected, actual);
        $display("Test failed");
        $fatal(1);
    end
endtask

`endif

/* tb_post_hash_pe_scheduler.sv */
`timescale 1ns/1ns

module tb_post_hash_pe_scheduler
    import hash_sched_pkg::*;
();

    localparam int SEED         = 32'h2cfc_9a3f;
    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES  = 12;
    localparam int TOTAL_BEATS  = 3 + 50 + 200 + 300 + 22;
    localparam int WATCHDOG_NS  = (TOTAL_BEATS * 20 + RESET_CYCLES) * 10;

    logic                       clk;
    logic                       rst_n;
    logic [QUEUE_CNT_WIDTH-1:0] cfg_max_queued_req_num;
    logic                       input_valid;
    pe_beat_t                   input_beat;
    logic                       input_ready;
    logic                       output_valid;
    issue_row_t                 output_row;
    logic                       output_ready;

    int         seed       = SEED;
    int         ready_seed = ~SEED;  // Separate stream for output_ready
    int         error_count = 0;
    int         accept_count = 0;
    logic       ready_random;
    string      test_name;
    issue_row_t expected_q [$];

    `include "tb_ref_model.svh"

    post_hash_pe_scheduler post_hash_pe_scheduler_inst (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .cfg_max_queued_req_num (cfg_max_queued_req_num),
        .input_valid            (input_valid),
        .input_beat             (input_beat),
        .input_ready            (input_ready),
        .output_valid           (output_valid),
        .output_row             (output_row),
        .output_ready           (output_ready)
    );

    always #5 clk = ~clk;

    function automatic hist_entry_t make_entry(input logic valid, input logic [3:0] len,
                                              input logic [ADDR_WIDTH-1:0] addr);
        hist_entry_t e;
        e.valid    = valid;
        e.addr     = addr;
        e.meta_len = len;
        e.can_ext  = len[0];
        return e;
    endfunction

    function automatic pe_lane_t make_lane(input logic [ADDR_WIDTH-1:0] addr, input logic delim,
                                           input hist_entry_t e0, input hist_entry_t e1);
        pe_lane_t lane;
        lane.addr   = addr;
        lane.delim  = delim;
        lane.data   = addr[7:0] ^ 8'h5a;
        lane.row[0] = e0;
        lane.row[1] = e1;
        return lane;
    endfunction

    // Active lanes share upper address bits, low bits are a permutation
    function automatic pe_beat_t random_beat();
        pe_beat_t              beat;
        int                    perm [NUM_HASH_PE];
        int                    j;
        int                    tmp;
        logic [ADDR_WIDTH-1:0] upper;
        for (int i = 0; i < NUM_HASH_PE; i++) begin
            perm[i] = i;
        end
        for (int i = NUM_HASH_PE - 1; i > 0; i--) begin
            j       = int'($unsigned($random(seed)) % (i + 1));
            tmp     = perm[i];
            perm[i] = perm[j];
            perm[j] = tmp;
        end
        upper     = ADDR_WIDTH'($random(seed));
        beat.mask = NUM_HASH_PE'($random(seed));
        for (int i = 0; i < NUM_HASH_PE; i++) begin
            beat.lane[i].addr  = {upper[ADDR_WIDTH-1:ISSUE_LOG2], ISSUE_LOG2'(perm[i])};
            beat.lane[i].delim = 1'($random(seed));
            beat.lane[i].data  = 8'($random(seed));
            for (int k = 0; k < ROW_SIZE; k++) begin
                beat.lane[i].row[k].valid    = 1'($random(seed));
                beat.lane[i].row[k].addr     = ADDR_WIDTH'($random(seed));
                // Narrow range so ties come up often
                beat.lane[i].row[k].meta_len =
                    META_MATCH_LEN_WIDTH'($unsigned($random(seed)) % 4);
                beat.lane[i].row[k].can_ext  = 1'($random(seed));
            end
        end
        return beat;
    endfunction

    task automatic send_beat(input pe_beat_t b);
        @(negedge clk);
        input_valid = 1'b1;
        input_beat  = b;
        @(posedge clk);
        while (!input_ready) @(posedge clk);
    endtask

    task automatic drive_idle();
        @(negedge clk);
        input_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    always @(negedge clk) begin
        if (ready_random) begin
            output_ready = 1'($random(ready_seed));
        end
    end

    // Scoreboard push on every input transfer
    always @(posedge clk) begin
        if (rst_n && input_valid && input_ready) begin
            expected_q.push_back(expected_row(input_beat));
            accept_count++;
        end
    end

    always @(posedge clk) begin
        issue_row_t exp_row;
        if (rst_n && output_valid && output_ready) begin
            if (expected_q.size() == 0) begin
                $display("ERROR: unexpected output row with no beat outstanding in %s",
                         test_name);
                $display("Test failed");
                $fatal(1);
            end else begin
                exp_row = expected_q.pop_front();
                check_value({test_name, " row"}, CHECK_W'(exp_row), CHECK_W'(output_row));
                check_value({test_name, " head_addr"}, CHECK_W'(exp_row.head_addr),
                            CHECK_W'(output_row.head_addr));
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog timeout, the stage stopped moving beats in %s", test_name);
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        pe_beat_t beat;
        int       start_count;
        logic     taken;
        clk                    = 1'b0;
        rst_n                  = 1'b0;
        cfg_max_queued_req_num = QUEUE_CNT_WIDTH'(QUEUE_DEPTH);
        input_valid            = 1'b0;
        input_beat             = '0;
        output_ready           = 1'b1;
        ready_random           = 1'b0;
        test_name              = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "candidate_select";
        beat.mask    = 4'hf;
        beat.lane[0] = make_lane(16'h3a42, 1'b0, make_entry(1'b1, 4'd3, 16'h0100),
                                 make_entry(1'b1, 4'd9, 16'h0200));
        beat.lane[1] = make_lane(16'h3a40, 1'b1, make_entry(1'b1, 4'd7, 16'h0300),
                                 make_entry(1'b1, 4'd7, 16'h0400));
        beat.lane[2] = make_lane(16'h3a43, 1'b0, make_entry(1'b0, 4'd15, 16'h0500),
                                 make_entry(1'b1, 4'd2, 16'h0600));
        beat.lane[3] = make_lane(16'h3a41, 1'b0, make_entry(1'b0, 4'd5, 16'h0700),
                                 make_entry(1'b0, 4'd8, 16'h0800));
        send_beat(beat);
        beat.mask    = 4'b0111;  // Lane 3 off, its slot stays empty
        beat.lane[0] = make_lane(16'hc17d, 1'b0, make_entry(1'b1, 4'd12, 16'h1100),
                                 make_entry(1'b1, 4'd4, 16'h1200));
        beat.lane[1] = make_lane(16'hc17f, 1'b0, make_entry(1'b1, 4'd0, 16'h1300),
                                 make_entry(1'b1, 4'd0, 16'h1400));
        beat.lane[2] = make_lane(16'hc17c, 1'b0, make_entry(1'b1, 4'd0, 16'h1500),
                                 make_entry(1'b1, 4'd1, 16'h1600));
        beat.lane[3] = make_lane(16'hc17e, 1'b1, make_entry(1'b1, 4'd9, 16'h1700),
                                 make_entry(1'b1, 4'd9, 16'h1800));
        send_beat(beat);
        beat.mask = 4'hf;
        for (int i = 0; i < NUM_HASH_PE; i++) begin
            beat.lane[i] = make_lane(16'h8000 | ADDR_WIDTH'(i), 1'b0,
                                     make_entry(1'b0, 4'd6, 16'h2000),
                                     make_entry(1'b0, 4'd6, 16'h2100));
        end
        send_beat(beat);
        drive_idle();
        wait_drain();

        test_name = "reorder";
        repeat (50) send_beat(random_beat());
        drive_idle();
        wait_drain();

        test_name = "streaming";
        repeat (200) send_beat(random_beat());
        drive_idle();
        wait_drain();

        test_name    = "back_pressure";
        ready_random = 1'b1;
        repeat (300) begin
            repeat ($unsigned($random(seed)) % 3) begin
                @(negedge clk);
                input_valid = 1'b0;
            end
            send_beat(random_beat());
        end
        drive_idle();
        ready_random = 1'b0;
        @(negedge clk);
        output_ready = 1'b1;
        wait_drain();

        for (int lim = 1; lim <= QUEUE_DEPTH; lim++) begin
            test_name = $sformatf("queue_limit_%0d", lim);
            @(negedge clk);
            output_ready           = 1'b0;
            cfg_max_queued_req_num = QUEUE_CNT_WIDTH'(lim);
            start_count            = accept_count;
            input_valid            = 1'b1;
            input_beat             = random_beat();
            repeat (HOLD_CYCLES) begin
                @(posedge clk);
                taken = input_ready;
                @(negedge clk);
                if (taken) begin
                    input_beat = random_beat();
                end
            end
            check_value({test_name, " accepted"}, CHECK_W'(lim + 2),
                        CHECK_W'(accept_count - start_count));
            output_ready = 1'b1;  // Pending beat goes in once space opens
            @(posedge clk);
            while (!input_ready) @(posedge clk);
            drive_idle();
            wait_drain();
        end

        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
hash_sched_pkg.sv
hash_row_merge.sv
reorder_crossbar.sv
hash_row_synchronizer.sv
post_hash_pe_scheduler.sv
tb_post_hash_pe_scheduler.sv

/* Makefile */
TOP  := tb_post_hash_pe_scheduler
SRCS := $(filter %.sv,$(shell cat sources.f))

all: obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f $(SRCS) tb_ref_model.svh
	verilator --binary --timescale 1ns/1ns -f sources.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

.PHONY: all run clean
